//--- verilog/fpu_add_pkg.sv
package fpu_add_pkg;

    // Single-precision field widths
    localparam int W   = 32;
    localparam int EW  = 8;
    localparam int SW  = 23;
    // Hidden bit, fraction and two guard bits
    localparam int SWR = 26;
    localparam int EWR = 5;

    typedef logic [W-1:0]   word_t;
    typedef logic [EW-1:0]  exp_t;
    typedef logic [SWR-1:0] sgf_t;
    typedef logic [EWR-1:0] shamt_t;

    // All-ones exponent encodes infinity
    localparam exp_t EXP_INF = '1;

    typedef enum logic [1:0] {
        RM_TRUNC     = 2'd0,
        RM_POS_INF   = 2'd1,
        RM_NEG_INF   = 2'd2,
        RM_TRUNC_ALT = 2'd3
    } rmode_t;

    // Exponent unit operations
    localparam logic [1:0] EXP_OP_DIFF = 2'd0;
    localparam logic [1:0] EXP_OP_INC  = 2'd1;
    localparam logic [1:0] EXP_OP_DEC  = 2'd2;

    // Shifter modes
    localparam logic [1:0] SH_ALIGN  = 2'd0;
    localparam logic [1:0] SH_NORM_R = 2'd1;
    localparam logic [1:0] SH_NORM_L = 2'd2;

    typedef enum logic [3:0] {
        IDLE, LOAD, EXP_DIFF, ALIGN, ADD, CHECK,
        NORM_R, LZD, NORM_L, ROUND, PACK, DONE
    } fsm_state_t;

endpackage

//--- verilog/fpu_ctrl_if.sv
`timescale 1ns/1ps

interface fpu_ctrl_if;

    // Load strobes and selectors from the FSM
    logic       ld_oper;
    logic       ld_exp;
    logic [1:0] exp_op;
    logic       ld_shift;
    logic [1:0] shift_mode;
    logic       ld_add;
    // High selects the rounding increment
    logic       add_sel;
    logic       ld_lzd;
    logic       ld_result;

    // Status back from the datapath
    logic       zero_flag;
    logic       add_carry;
    logic       round_flag;

    modport fsm (
        output ld_oper, ld_exp, exp_op, ld_shift, shift_mode,
        output ld_add, add_sel, ld_lzd, ld_result,
        input  zero_flag, add_carry, round_flag
    );

    modport dp (
        input  ld_oper, ld_exp, exp_op, ld_shift, shift_mode,
        input  ld_add, add_sel, ld_lzd, ld_result,
        output zero_flag, add_carry, round_flag
    );

endinterface

//--- verilog/fpu_add_fsm.sv
`timescale 1ns/1ps

module fpu_add_fsm import fpu_add_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    beg_i,
    input  logic    ack_i,
    fpu_ctrl_if.fsm ctrl,
    output logic    ready_o
);

    fsm_state_t state_q, state_d;
    // Rounding increment has been applied once
    logic rounded_q, rounded_d;
    // Exponent still owes the left normalization count
    logic dec_pend_q, dec_pend_d;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= IDLE;
            rounded_q  <= 1'b0;
            dec_pend_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            rounded_q  <= rounded_d;
            dec_pend_q <= dec_pend_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        rounded_d       = rounded_q;
        dec_pend_d      = dec_pend_q;
        ctrl.ld_oper    = 1'b0;
        ctrl.ld_exp     = 1'b0;
        ctrl.exp_op     = EXP_OP_DIFF;
        ctrl.ld_shift   = 1'b0;
        ctrl.shift_mode = SH_ALIGN;
        ctrl.ld_add     = 1'b0;
        ctrl.add_sel    = rounded_q;
        ctrl.ld_lzd     = 1'b0;
        ctrl.ld_result  = 1'b0;

        case (state_q)
            IDLE: begin
                if (beg_i)
                    state_d = LOAD;
            end
            LOAD: begin
                ctrl.ld_oper = 1'b1;
                rounded_d    = 1'b0;
                dec_pend_d   = 1'b0;
                state_d      = EXP_DIFF;
            end
            EXP_DIFF: begin
                ctrl.ld_exp = 1'b1;
                ctrl.exp_op = EXP_OP_DIFF;
                // Zero result skips the whole datapath
                state_d     = ctrl.zero_flag ? PACK : ALIGN;
            end
            ALIGN: begin
                ctrl.ld_shift   = 1'b1;
                ctrl.shift_mode = SH_ALIGN;
                state_d         = ADD;
            end
            ADD: begin
                ctrl.ld_add = 1'b1;
                state_d     = CHECK;
            end
            CHECK: begin
                if (ctrl.add_carry) begin
                    // Bump the exponent now, shift in NORM_R
                    ctrl.ld_exp = 1'b1;
                    ctrl.exp_op = EXP_OP_INC;
                    state_d     = NORM_R;
                end else begin
                    state_d = LZD;
                end
            end
            NORM_R: begin
                ctrl.ld_shift   = 1'b1;
                ctrl.shift_mode = SH_NORM_R;
                state_d         = ROUND;
            end
            LZD: begin
                ctrl.ld_lzd = 1'b1;
                state_d     = NORM_L;
            end
            NORM_L: begin
                ctrl.ld_shift   = 1'b1;
                ctrl.shift_mode = SH_NORM_L;
                dec_pend_d      = 1'b1;
                state_d         = ROUND;
            end
            ROUND: begin
                ctrl.ld_exp = dec_pend_q;
                ctrl.exp_op = EXP_OP_DEC;
                dec_pend_d  = 1'b0;
                if (ctrl.round_flag && !rounded_q) begin
                    rounded_d = 1'b1;
                    state_d   = ADD;
                end else begin
                    state_d = PACK;
                end
            end
            PACK: begin
                ctrl.ld_result = 1'b1;
                state_d        = DONE;
            end
            DONE: begin
                if (ack_i)
                    state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    assign ready_o = (state_q == DONE);

    // Datapath registers advance one stage per cycle
    assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({ctrl.ld_shift, ctrl.ld_add, ctrl.ld_exp}));

    // Result stays presented until acknowledged
    assert property (@(posedge clk) disable iff (rst_i)
        ready_o && !ack_i |=> ready_o);

endmodule

//--- verilog/operand_sorter.sv
`timescale 1ns/1ps

module operand_sorter import fpu_add_pkg::*; (
    input  logic         clk,
    input  logic         rst_i,
    input  word_t        x_i,
    input  word_t        y_i,
    input  logic         sub_i,
    fpu_ctrl_if.dp       ctrl,
    output logic [W-2:0] big_o,
    output logic [W-2:0] small_o,
    output logic         sign_o,
    output logic         real_op_o
);

    word_t x_q;
    word_t y_q;
    logic  x_big;
    logic  same_mag;
    logic  cancel;
    logic  both_zero;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (ctrl.ld_oper) begin
            x_q <= x_i;
            // Subtraction adds the negated Y
            y_q <= {y_i[W-1] ^ sub_i, y_i[W-2:0]};
        end
    end

    // Exponent above fraction lets magnitudes compare as integers
    assign x_big    = (x_q[W-2:0] >= y_q[W-2:0]);
    assign same_mag = (x_q[W-2:0] == y_q[W-2:0]);

    assign big_o   = x_big ? x_q[W-2:0] : y_q[W-2:0];
    assign small_o = x_big ? y_q[W-2:0] : x_q[W-2:0];

    assign real_op_o = x_q[W-1] ^ y_q[W-1];
    assign cancel    = real_op_o && same_mag;
    assign both_zero = (x_q[W-2:SW] == '0) && (y_q[W-2:SW] == '0);

    // Exact cancellation yields +0
    assign sign_o = cancel ? 1'b0 : (x_big ? x_q[W-1] : y_q[W-1]);

    assign ctrl.zero_flag = cancel || both_zero;

endmodule

//--- verilog/exp_unit.sv
`timescale 1ns/1ps

module exp_unit import fpu_add_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  exp_t   big_exp_i,
    input  exp_t   small_exp_i,
    input  shamt_t lzc_i,
    fpu_ctrl_if.dp ctrl,
    output exp_t   exp_o,
    output shamt_t diff_o,
    output logic   overflow_o,
    output logic   underflow_o
);

    exp_t raw_diff;

    assign raw_diff = big_exp_i - small_exp_i;

    always_ff @(posedge clk) begin
        if (ctrl.ld_exp) begin
            case (ctrl.exp_op)
                EXP_OP_DIFF: begin
                    exp_o  <= big_exp_i;
                    // Past the full width everything aligns out
                    diff_o <= (raw_diff > exp_t'(SWR)) ? shamt_t'(SWR) : shamt_t'(raw_diff);
                end
                EXP_OP_INC: exp_o <= exp_o + 1'b1;
                EXP_OP_DEC: exp_o <= exp_o - exp_t'(lzc_i);
                default: ;
            endcase
        end
    end

    // Flags are sticky for the rest of the operation
    always_ff @(posedge clk) begin
        if (rst_i || ctrl.ld_oper) begin
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (ctrl.ld_exp) begin
            if (ctrl.exp_op == EXP_OP_INC && exp_o >= EXP_INF - 1'b1)
                overflow_o <= 1'b1;
            // Result at or below zero cannot be a normal number
            if (ctrl.exp_op == EXP_OP_DEC && exp_o <= exp_t'(lzc_i))
                underflow_o <= 1'b1;
        end
    end

endmodule

//--- verilog/sgf_shifter.sv
`timescale 1ns/1ps

module sgf_shifter import fpu_add_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  sgf_t   small_i,
    input  sgf_t   sum_i,
    input  shamt_t diff_i,
    input  shamt_t lzc_i,
    fpu_ctrl_if.dp ctrl,
    output sgf_t   sgf_o
);

    sgf_t shifted;

    always_comb begin
        case (ctrl.shift_mode)
            SH_ALIGN:  shifted = small_i >> diff_i;
            // Adder carry becomes the new hidden bit
            SH_NORM_R: shifted = {ctrl.add_carry, sum_i[SWR-1:1]};
            SH_NORM_L: shifted = sum_i << lzc_i;
            default:   shifted = sum_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            sgf_o <= '0;
        else if (ctrl.ld_shift)
            sgf_o <= shifted;
    end

endmodule

//--- verilog/sgf_adder_lzd.sv
`timescale 1ns/1ps

module sgf_adder_lzd import fpu_add_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  sgf_t   big_i,
    input  sgf_t   aligned_i,
    input  sgf_t   norm_i,
    input  logic   real_op_i,
    fpu_ctrl_if.dp ctrl,
    output sgf_t   sum_o,
    output shamt_t lzc_o
);

    // One unit in the last place sits above the guard bits
    localparam sgf_t ULP = sgf_t'(4);

    logic [SWR:0] sum_full;
    logic         carry_q;

    function automatic shamt_t count_lz(input sgf_t v);
        shamt_t n;
        logic   found;
        n     = shamt_t'(SWR);
        found = 1'b0;
        for (int i = SWR - 1; i >= 0; i--) begin
            if (v[i] && !found) begin
                n     = shamt_t'(SWR - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        if (ctrl.add_sel)
            sum_full = {1'b0, norm_i} + {1'b0, ULP};
        else if (real_op_i)
            sum_full = {1'b0, big_i} - {1'b0, aligned_i};
        else
            sum_full = {1'b0, big_i} + {1'b0, aligned_i};
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_add)
            sum_o <= sum_full[SWR-1:0];
        if (ctrl.ld_lzd)
            lzc_o <= count_lz(sum_o);
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            carry_q <= 1'b0;
        else if (ctrl.ld_add)
            carry_q <= sum_full[SWR];
    end

    assign ctrl.add_carry = carry_q;

    // Sorting keeps the magnitude difference non-negative
    assert property (@(posedge clk) disable iff (rst_i)
        ctrl.ld_add && !ctrl.add_sel && real_op_i |=> !ctrl.add_carry);

endmodule

//--- verilog/result_pack.sv
`timescale 1ns/1ps

module result_pack import fpu_add_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  sgf_t   norm_i,
    input  exp_t   exp_i,
    input  logic   sign_i,
    input  rmode_t r_mode_i,
    input  logic   overflow_i,
    input  logic   underflow_i,
    fpu_ctrl_if.dp ctrl,
    output word_t  result_o
);

    logic guard_nz;
    logic dir_up;

    assign guard_nz = |norm_i[1:0];

    // Only the directed modes move away from zero
    always_comb begin
        case (r_mode_i)
            RM_POS_INF: dir_up = !sign_i;
            RM_NEG_INF: dir_up = sign_i;
            default:    dir_up = 1'b0;
        endcase
    end

    assign ctrl.round_flag = guard_nz && dir_up;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o <= '0;
        end else if (ctrl.ld_result) begin
            if (overflow_i)
                result_o <= {sign_i, EXP_INF, {SW{1'b0}}};
            else if (underflow_i || ctrl.zero_flag)
                result_o <= {sign_i, {(W-1){1'b0}}};
            else
                // Hidden bit and guard bits are dropped here
                result_o <= {sign_i, exp_i, norm_i[SWR-2:2]};
        end
    end

endmodule

//--- verilog/fpu_add_sub.sv
`timescale 1ns/1ps

module fpu_add_sub import fpu_add_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   beg_i,
    input  logic   ack_i,
    input  word_t  x_i,
    input  word_t  y_i,
    input  logic   sub_i,
    input  rmode_t r_mode_i,
    output word_t  result_o,
    output logic   overflow_o,
    output logic   underflow_o,
    output logic   ready_o
);

    fpu_ctrl_if ctrl ();

    logic [W-2:0] big_mag;
    logic [W-2:0] small_mag;
    logic         sign;
    logic         real_op;
    sgf_t         big_sgf;
    sgf_t         small_sgf;
    sgf_t         shift_sgf;
    sgf_t         sum_sgf;
    exp_t         exp_val;
    shamt_t       diff;
    shamt_t       lzc;

    // Zero exponent reads as zero, so no hidden bit
    assign big_sgf   = {|big_mag[W-2:SW], big_mag[SW-1:0], 2'b00};
    assign small_sgf = {|small_mag[W-2:SW], small_mag[SW-1:0], 2'b00};

    fpu_add_fsm u_fsm (
        .clk     (clk),
        .rst_i   (rst_i),
        .beg_i   (beg_i),
        .ack_i   (ack_i),
        .ctrl    (ctrl.fsm),
        .ready_o (ready_o)
    );

    operand_sorter u_sorter (
        .clk       (clk),
        .rst_i     (rst_i),
        .x_i       (x_i),
        .y_i       (y_i),
        .sub_i     (sub_i),
        .ctrl      (ctrl.dp),
        .big_o     (big_mag),
        .small_o   (small_mag),
        .sign_o    (sign),
        .real_op_o (real_op)
    );

    exp_unit u_exp (
        .clk         (clk),
        .rst_i       (rst_i),
        .big_exp_i   (big_mag[W-2:SW]),
        .small_exp_i (small_mag[W-2:SW]),
        .lzc_i       (lzc),
        .ctrl        (ctrl.dp),
        .exp_o       (exp_val),
        .diff_o      (diff),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    sgf_shifter u_shifter (
        .clk     (clk),
        .rst_i   (rst_i),
        .small_i (small_sgf),
        .sum_i   (sum_sgf),
        .diff_i  (diff),
        .lzc_i   (lzc),
        .ctrl    (ctrl.dp),
        .sgf_o   (shift_sgf)
    );

    sgf_adder_lzd u_adder (
        .clk       (clk),
        .rst_i     (rst_i),
        .big_i     (big_sgf),
        .aligned_i (shift_sgf),
        .norm_i    (shift_sgf),
        .real_op_i (real_op),
        .ctrl      (ctrl.dp),
        .sum_o     (sum_sgf),
        .lzc_o     (lzc)
    );

    result_pack u_pack (
        .clk         (clk),
        .rst_i       (rst_i),
        .norm_i      (shift_sgf),
        .exp_i       (exp_val),
        .sign_i      (sign),
        .r_mode_i    (r_mode_i),
        .overflow_i  (overflow_o),
        .underflow_i (underflow_o),
        .ctrl        (ctrl.dp),
        .result_o    (result_o)
    );

endmodule

//--- tests/fpu_add_sub_tb.sv
`timescale 1ns/1ps

module fpu_add_sub_tb import fpu_add_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 15;
    localparam int HOLD_CYCLES  = 5;
    localparam int READY_LIMIT  = 40;
    // Twenty cycles per entry plus the reset phase
    localparam int WATCHDOG_NS  = (NUM_TESTS * 20 + RESET_CYCLES) * CLK_PERIOD;

    typedef logic [8*20-1:0] name_t;

    typedef struct packed {
        name_t  name;
        word_t  x;
        word_t  y;
        logic   sub;
        rmode_t r_mode;
        word_t  result;
        logic   overflow;
        logic   underflow;
    } vector_t;

    logic   clk;
    logic   rst_i;
    logic   beg_i;
    logic   ack_i;
    word_t  x_i;
    word_t  y_i;
    logic   sub_i;
    rmode_t r_mode_i;
    word_t  result_o;
    logic   overflow_o;
    logic   underflow_o;
    logic   ready_o;

    vector_t tests [NUM_TESTS];

    fpu_add_sub dut_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .beg_i       (beg_i),
        .ack_i       (ack_i),
        .x_i         (x_i),
        .y_i         (y_i),
        .sub_i       (sub_i),
        .r_mode_i    (r_mode_i),
        .result_o    (result_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .ready_o     (ready_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Expected words worked out by hand from the IEEE fields
    task automatic load_table();
        tests[0]  = '{"add_one_one",    32'h3F800000, 32'h3F800000, 1'b0, RM_TRUNC,
                      32'h40000000, 1'b0, 1'b0};
        tests[1]  = '{"sub_three_one",  32'h40400000, 32'h3F800000, 1'b1, RM_TRUNC,
                      32'h40000000, 1'b0, 1'b0};
        tests[2]  = '{"add_two_one",    32'h40000000, 32'h3F800000, 1'b0, RM_TRUNC,
                      32'h40400000, 1'b0, 1'b0};
        tests[3]  = '{"cancel",         32'h3FC00000, 32'h3FC00000, 1'b1, RM_TRUNC,
                      32'h00000000, 1'b0, 1'b0};
        tests[4]  = '{"norm_left",      32'h3F800001, 32'h3F800000, 1'b1, RM_TRUNC,
                      32'h34000000, 1'b0, 1'b0};
        // Small operand leaves both guard bits set
        tests[5]  = '{"round_trunc",    32'h3F800000, 32'h33C00000, 1'b0, RM_TRUNC,
                      32'h3F800000, 1'b0, 1'b0};
        tests[6]  = '{"round_pos_up",   32'h3F800000, 32'h33C00000, 1'b0, RM_POS_INF,
                      32'h3F800001, 1'b0, 1'b0};
        tests[7]  = '{"round_neg_down", 32'hBF800000, 32'hB3C00000, 1'b0, RM_NEG_INF,
                      32'hBF800001, 1'b0, 1'b0};
        tests[8]  = '{"round_neg_pos",  32'h3F800000, 32'h33C00000, 1'b0, RM_NEG_INF,
                      32'h3F800000, 1'b0, 1'b0};
        tests[9]  = '{"round_pos_neg",  32'hBF800000, 32'hB3C00000, 1'b0, RM_POS_INF,
                      32'hBF800000, 1'b0, 1'b0};
        tests[10] = '{"round_alt",      32'h3F800000, 32'h33C00000, 1'b0, RM_TRUNC_ALT,
                      32'h3F800000, 1'b0, 1'b0};
        tests[11] = '{"overflow",       32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RM_TRUNC,
                      32'h7F800000, 1'b1, 1'b0};
        tests[12] = '{"underflow",      32'h00800001, 32'h00800000, 1'b1, RM_TRUNC,
                      32'h00000000, 1'b0, 1'b1};
        tests[13] = '{"zero_operand",   32'h00000000, 32'h3F800000, 1'b0, RM_TRUNC,
                      32'h3F800000, 1'b0, 1'b0};
        tests[14] = '{"both_zero",      32'h00000000, 32'h00000000, 1'b0, RM_TRUNC,
                      32'h00000000, 1'b0, 1'b0};
    endtask

    // Step to just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input name_t name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %0s %0s expected %h actual %h", name, field, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic start_op(input vector_t t);
        x_i      = t.x;
        y_i      = t.y;
        sub_i    = t.sub;
        r_mode_i = t.r_mode;
        beg_i    = 1'b1;
        next_cycle();
        beg_i    = 1'b0;
    endtask

    task automatic wait_ready(input name_t name);
        int cycles;
        cycles = 0;
        while (ready_o !== 1'b1) begin
            if (cycles == READY_LIMIT) begin
                $display("ready_o never rose during test %0s", name);
                $display("SOME TESTS FAILED");
                $fatal(1, "handshake timeout");
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Withhold ack and watch the result stay put
    task automatic hold_check(input name_t name);
        word_t held;
        held = result_o;
        repeat (HOLD_CYCLES) begin
            next_cycle();
            check_value(name, "ready_o held", 32'd1, {31'd0, ready_o});
            check_value(name, "result held", held, result_o);
        end
    endtask

    task automatic finish_op(input name_t name);
        ack_i = 1'b1;
        next_cycle();
        ack_i = 1'b0;
        check_value(name, "ready_o after ack", 32'd0, {31'd0, ready_o});
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        beg_i       = 1'b0;
        ack_i       = 1'b0;
        x_i         = '0;
        y_i         = '0;
        sub_i       = 1'b0;
        r_mode_i    = RM_TRUNC;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_i = 1'b0;
        check_value("reset", "ready_o", 32'd0, {31'd0, ready_o});
        check_value("reset", "overflow_o", 32'd0, {31'd0, overflow_o});
        check_value("reset", "underflow_o", 32'd0, {31'd0, underflow_o});

        for (int i = 0; i < NUM_TESTS; i++) begin
            start_op(tests[i]);
            wait_ready(tests[i].name);
            check_value(tests[i].name, "result", tests[i].result, result_o);
            check_value(tests[i].name, "overflow", {31'd0, tests[i].overflow},
                        {31'd0, overflow_o});
            check_value(tests[i].name, "underflow", {31'd0, tests[i].underflow},
                        {31'd0, underflow_o});
            if (i == 0)
                hold_check(tests[i].name);
            finish_op(tests[i].name);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- flist.f
verilog/fpu_add_pkg.sv
verilog/fpu_ctrl_if.sv
verilog/fpu_add_fsm.sv
verilog/operand_sorter.sv
verilog/exp_unit.sv
verilog/sgf_shifter.sv
verilog/sgf_adder_lzd.sv
verilog/result_pack.sv
verilog/fpu_add_sub.sv
tests/fpu_add_sub_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := fpu_add_sub_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
